/* sources.f */
design/encoder_pkg.sv
design/symbol_pkg.sv
design/osc_divider.sv
design/code_register.sv
design/symbol_shaper.sv
design/frame_sequencer.sv
design/pt2262_encoder.sv
bench/encoder_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the PT2262 encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sources.f --top-module encoder_tb -o encoder_sim

# The testbench prints its verdict, pass only on the exact pass line
sim_out=$(./obj_dir/encoder_sim)
echo "$sim_out"

if grep -qx "Done: no errors" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* bench/encoder_tb.sv */
`timescale 1ns/1ps

// Directed tests for the PT2262 style encoder
// A decoder on cod_o turns run lengths back into code words
module encoder_tb;

    // Expected widths in clocks, from alpha lengths and the divider ratio
    localparam int SHORT_CLK    = encoder_pkg::SHORT_ALPHA * encoder_pkg::OSC_DIV;  // 16
    localparam int LONG_CLK     = encoder_pkg::LONG_ALPHA * encoder_pkg::OSC_DIV;   // 48
    localparam int SYNC_GAP_CLK = (encoder_pkg::SYNC_ALPHA - encoder_pkg::SHORT_ALPHA)
                                  * encoder_pkg::OSC_DIV;                          // 496
    localparam int SYMBOL_CLK   = 2 * (SHORT_CLK + LONG_CLK);                      // 128
    localparam int FRAME_CLK    = encoder_pkg::NUM_SYMBOLS * SYMBOL_CLK
                                  + encoder_pkg::SYNC_ALPHA * encoder_pkg::OSC_DIV; // 2048
    localparam int NUM_FRAMES   = 11;       // Frames sent over all tests
    localparam int MAX_CYCLES   = (NUM_FRAMES + 1) * FRAME_CLK + 5000;

    logic                   clk = 1'b0;     // Low from the start, no edge at time zero
    logic                   reset;
    logic                   send;
    symbol_pkg::code_word_t code_in;
    logic                   cod_o;
    logic                   sync;

    int          mismatch_count;
    int          other_count;
    int          cyc;               // Clocks since time zero

    // Decoder state
    logic                   level;          // Level of the current run
    logic                   prev_level;
    int                     run_len;        // Clocks in the current run
    int                     hi_len;         // Last high run, 0 when none pending
    logic                   pulse_pending;  // First pulse of a symbol seen
    logic                   first_bit;
    logic                   in_frame;
    int                     sync_count;
    symbol_pkg::symbol_t    syms[$];        // Symbols of the frame in progress
    symbol_pkg::code_word_t frames[$];      // Decoded words, oldest first
    int                     start_cycles[$]; // Cycle of each first rising edge

    // Marks at the start of each test
    int frame_base;
    int start_base;
    int sync_base;

    pt2262_encoder uut (
        .clk     (clk),
        .reset   (reset),
        .send    (send),
        .code_in (code_in),
        .cod_o   (cod_o),
        .sync    (sync)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s (got 0x%0h, expected 0x%0h)",
                     $time, what, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        other_count++;
    endtask

    // One high run plus one low run, then pairs of pulses into a symbol
    task automatic finish_pulse(input int hi, input int lo);
        logic                bit_val;
        symbol_pkg::symbol_t sym;
        bit_val = 1'b0;
        sym     = symbol_pkg::SYM_ZERO;
        if (hi == SHORT_CLK && lo == LONG_CLK) begin
            bit_val = 1'b0;
        end else if (hi == LONG_CLK && lo == SHORT_CLK) begin
            bit_val = 1'b1;
        end else begin
            report_failure($sformatf("pulse of %0d clocks high and %0d low is no valid pulse",
                                     hi, lo));
        end
        if (!pulse_pending) begin
            first_bit     = bit_val;
            pulse_pending = 1'b1;
        end else begin
            pulse_pending = 1'b0;
            case ({first_bit, bit_val})
                2'b00:   sym = symbol_pkg::SYM_ZERO;
                2'b11:   sym = symbol_pkg::SYM_ONE;
                2'b01:   sym = symbol_pkg::SYM_FLOAT;   // Zero pulse then one pulse
                default: report_failure("one pulse followed by zero pulse is no valid symbol");
            endcase
            syms.push_back(sym);
        end
    endtask

    // Sync gap reached, rebuild the word
    task automatic finish_frame();
        logic [15:0] addr_bits;
        logic [3:0]  data_bits;
        int          i;
        check(hi_len, SHORT_CLK, "sync high width");
        if (pulse_pending) begin
            report_failure("frame ended halfway through a symbol");
        end
        if (syms.size() != encoder_pkg::NUM_SYMBOLS) begin
            report_failure($sformatf("frame ended after %0d symbols instead of %0d",
                                     syms.size(), encoder_pkg::NUM_SYMBOLS));
        end else begin
            for (i = encoder_pkg::NUM_ADDR; i < encoder_pkg::NUM_SYMBOLS; i++) begin
                if (syms[i] != symbol_pkg::SYM_ZERO && syms[i] != symbol_pkg::SYM_ONE) begin
                    report_failure($sformatf("data bit %0d decoded as floating",
                                             i - encoder_pkg::NUM_ADDR));
                end
            end
            // A7 down to A0
            addr_bits = {syms[7], syms[6], syms[5], syms[4],
                         syms[3], syms[2], syms[1], syms[0]};
            data_bits = {syms[11] == symbol_pkg::SYM_ONE, syms[10] == symbol_pkg::SYM_ONE,
                         syms[9] == symbol_pkg::SYM_ONE, syms[8] == symbol_pkg::SYM_ONE};
            frames.push_back(symbol_pkg::code_word_t'({addr_bits, data_bits}));
        end
        syms.delete();
        pulse_pending = 1'b0;
        hi_len        = 0;
        in_frame      = 1'b0;
    endtask

    // Waveform decoder, samples away from the driving edge
    initial begin
        forever begin
            @(negedge clk);
            if (reset) begin
                level         = 1'b0;
                run_len       = 0;
                hi_len        = 0;
                pulse_pending = 1'b0;
                in_frame      = 1'b0;
                syms.delete();
            end else begin
                prev_level = level;
                if (cod_o == level) begin
                    run_len++;
                    if (!level && hi_len != 0 && run_len == SYNC_GAP_CLK) begin
                        finish_frame();
                    end
                end else begin
                    if (level) begin
                        hi_len = run_len;
                    end else if (hi_len != 0 && run_len < SYNC_GAP_CLK) begin
                        finish_pulse(hi_len, run_len);
                        hi_len = 0;
                    end
                    if (cod_o && !in_frame) begin
                        in_frame = 1'b1;            // First rise of a new frame
                        start_cycles.push_back(cyc);
                    end
                    level   = cod_o;
                    run_len = 1;
                end
                if (sync) begin
                    sync_count++;
                    if (!(cod_o && !prev_level)) begin
                        report_failure("sync pulse away from a rising edge of cod_o");
                    end
                    check(syms.size(), encoder_pkg::NUM_SYMBOLS, "symbols before sync");
                end
            end
        end
    end

    // Watchdog on the cycle counter
    initial begin
        cyc = 0;
        while (cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
        $display("Done: errors found");
        $finish;
    end

    // Address symbols 0, 1 or F only, never sync
    function automatic symbol_pkg::code_word_t random_word();
        logic [15:0] addr_bits;
        addr_bits = '0;
        repeat (encoder_pkg::NUM_ADDR) addr_bits = {addr_bits[13:0], 2'($urandom % 3)};
        return symbol_pkg::code_word_t'({addr_bits, 4'($urandom)});
    endfunction

    task automatic mark_records();
        @(posedge clk);
        frame_base = frames.size();
        start_base = start_cycles.size();
        sync_base  = sync_count;
    endtask

    task automatic wait_for_starts(input int n);
        while (start_cycles.size() < start_base + n) @(posedge clk);
    endtask

    task automatic wait_for_frames(input int n);
        while (frames.size() < frame_base + n) @(posedge clk);
    endtask

    task automatic idle_during_reset();
        int high_seen;
        high_seen = 0;
        repeat (2) begin
            @(negedge clk);
            check(32'(cod_o), 0, "cod_o during reset");
            check(32'(sync), 0, "sync during reset");
        end
        @(posedge clk);
        reset <= 1'b0;                      // Third rising edge
        repeat (200) begin
            @(negedge clk);
            if (cod_o || sync) high_seen++;
        end
        check(high_seen, 0, "clocks with cod_o or sync high while send is low");
        check(start_cycles.size(), 0, "frames started while send is low");
    endtask

    task automatic fixed_frame();
        symbol_pkg::code_word_t word;
        // A7..A0 = 1 F 0 1 F F 1 0, data 1010
        word = symbol_pkg::code_word_t'({symbol_pkg::SYM_ONE, symbol_pkg::SYM_FLOAT,
                                         symbol_pkg::SYM_ZERO, symbol_pkg::SYM_ONE,
                                         symbol_pkg::SYM_FLOAT, symbol_pkg::SYM_FLOAT,
                                         symbol_pkg::SYM_ONE, symbol_pkg::SYM_ZERO,
                                         4'b1010});
        mark_records();
        code_in <= word;
        send    <= 1'b1;
        wait_for_starts(1);
        send <= 1'b0;                       // Just this one frame
        wait_for_frames(1);
        check(32'(frames[frame_base]), 32'(word), "fixed frame word");
        check(sync_count - sync_base, 1, "sync pulses in one frame");
    endtask

    task automatic back_to_back_frames();
        symbol_pkg::code_word_t word;
        word = random_word();
        mark_records();
        code_in <= word;
        send    <= 1'b1;
        wait_for_starts(2);
        send <= 1'b0;
        wait_for_frames(2);
        check(32'(frames[frame_base]), 32'(word), "first of two frames");
        check(32'(frames[frame_base + 1]), 32'(word), "second of two frames");
        check(start_cycles[start_base + 1] - start_cycles[start_base], FRAME_CLK,
              "clocks between back to back frame starts");
        check(sync_count - sync_base, 2, "sync pulses in two frames");
    endtask

    task automatic code_change_mid_frame();
        symbol_pkg::code_word_t old_word;
        symbol_pkg::code_word_t new_word;
        old_word      = random_word();
        new_word      = random_word();
        new_word.data = ~old_word.data;     // Always differs
        mark_records();
        code_in <= old_word;
        send    <= 1'b1;
        wait_for_starts(1);
        repeat (FRAME_CLK / 3) @(posedge clk);
        code_in <= new_word;                // Mid frame
        wait_for_starts(2);
        send <= 1'b0;
        wait_for_frames(2);
        check(32'(frames[frame_base]), 32'(old_word), "frame in flight during code change");
        check(32'(frames[frame_base + 1]), 32'(new_word), "frame after code change");
    endtask

    task automatic release_mid_frame();
        symbol_pkg::code_word_t word;
        int                     high_seen;
        word      = random_word();
        high_seen = 0;
        mark_records();
        code_in <= word;
        send    <= 1'b1;
        wait_for_starts(1);
        repeat (FRAME_CLK / 2) @(posedge clk);
        send <= 1'b0;
        wait_for_frames(1);
        check(32'(frames[frame_base]), 32'(word), "frame with send released mid frame");
        check(sync_count - sync_base, 1, "sync of the released frame");
        repeat (1000) begin
            @(negedge clk);
            if (cod_o) high_seen++;
        end
        check(high_seen, 0, "clocks with cod_o high after the last frame");
        check(start_cycles.size() - start_base, 1, "frames started after send release");
    endtask

    task automatic random_frames();
        symbol_pkg::code_word_t word;
        symbol_pkg::code_word_t expected[$];
        int                     i;
        mark_records();
        word = random_word();
        code_in <= word;
        send    <= 1'b1;
        for (i = 0; i < 5; i++) begin
            wait_for_starts(i + 1);
            expected.push_back(word);       // Captured just before cod_o rose
            if (i < 4) begin
                word = random_word();
                code_in <= word;
            end else begin
                send <= 1'b0;
            end
        end
        wait_for_frames(5);
        for (i = 0; i < 5; i++) begin
            check(32'(frames[frame_base + i]), 32'(expected[i]),
                  $sformatf("random frame %0d", i));
        end
    endtask

    initial begin
        void'($urandom(92));
        mismatch_count = 0;
        other_count    = 0;
        sync_count     = 0;
        reset          = 1'b1;
        send           = 1'b0;
        code_in        = '0;

        idle_during_reset();
        fixed_frame();
        back_to_back_frames();
        code_change_mid_frame();
        release_mid_frame();
        random_frames();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* design/pt2262_encoder.sv */
`timescale 1ns/1ps

// PT2262 style encoder, single clock domain
// Everything steps on the alpha tick from the divider
module pt2262_encoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   send,      // Transmit enable
    input  symbol_pkg::code_word_t code_in,   // Address symbols and data bits
    output logic                   cod_o,     // Serial coded output
    output logic                   sync       // One clock at each sync start
);

    logic                   tick;       // Alpha strobe
    logic                   load;       // Capture pulse from the FSM
    logic                   sym_start;
    logic                   sym_done;
    symbol_pkg::symbol_t    sym_kind;
    symbol_pkg::code_word_t code;       // Word held for the frame

    osc_divider u_osc (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    code_register u_code (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .code_in (code_in),
        .code    (code)
    );

    frame_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .send      (send),
        .code      (code),
        .sym_done  (sym_done),
        .load      (load),
        .sym_start (sym_start),
        .sym_kind  (sym_kind),
        .sync      (sync)
    );

    symbol_shaper u_shaper (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .sym_start (sym_start),
        .sym_kind  (sym_kind),
        .cod_o     (cod_o),
        .sym_done  (sym_done)
    );

endmodule

/* design/frame_sequencer.sv */
`timescale 1ns/1ps

// Frame FSM
// Steps A0..A7, D0..D3, then sync, and repeats while send is held
module frame_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tick,       // Alpha strobe
    input  logic                   send,       // Transmit enable level
    input  symbol_pkg::code_word_t code,       // Captured word
    input  logic                   sym_done,   // Shaper finished a symbol
    output logic                   load,       // Capture code_in, one clock
    output logic                   sym_start,  // Begin next symbol, with a tick
    output symbol_pkg::symbol_t    sym_kind,   // Kind of the current symbol
    output logic                   sync        // First clock of the sync symbol
);

    typedef enum logic {
        IDLE,
        SENDING
    } state_t;

    state_t                 state;
    encoder_pkg::sym_idx_t  index;         // 0..11 code symbols, 12 sync
    encoder_pkg::data_idx_t data_off;      // Data bit for index 8..11
    logic                   start_frame;   // Leave idle this tick
    logic                   last_sym;      // Sync symbol in progress
    logic                   next_sym;      // Advance inside the frame
    logic                   sync_next;     // Sync is the next symbol to start

    assign last_sym  = (index == encoder_pkg::sym_idx_t'(encoder_pkg::NUM_SYMBOLS));
    assign data_off  = encoder_pkg::data_idx_t'(index
                       - encoder_pkg::sym_idx_t'(encoder_pkg::NUM_ADDR));

    // Frame start only on a tick, keeps symbols aligned to alpha
    assign start_frame = (state == IDLE) && tick && send;
    assign next_sym    = (state == SENDING) && sym_done && !last_sym;
    assign sync_next   = next_sym
                         && (index == encoder_pkg::sym_idx_t'(encoder_pkg::NUM_SYMBOLS - 1));

    // Reload right after the sync when send is still high, no gap
    assign load      = start_frame || ((state == SENDING) && sym_done && last_sym && send);
    assign sym_start = load || next_sym;

    // Symbol select
    always_comb begin
        if (index < encoder_pkg::sym_idx_t'(encoder_pkg::NUM_ADDR)) begin
            sym_kind = code.addr[encoder_pkg::addr_idx_t'(index)];
        end else if (!last_sym) begin
            sym_kind = code.data[data_off] ? symbol_pkg::SYM_ONE : symbol_pkg::SYM_ZERO;
        end else begin
            sym_kind = symbol_pkg::SYM_SYNC;
        end
    end

    // State and index
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            index <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_frame) begin
                        state <= SENDING;
                        index <= '0;
                    end
                end
                SENDING: begin
                    if (sym_done) begin
                        if (!last_sym) begin
                            index <= index + 1'b1;
                        end else begin
                            index <= '0;         // Frame over, maybe another
                            if (!send) begin
                                state <= IDLE;   // Release only seen at frame end
                            end
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Registered so it lines up with the rising edge of cod_o
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync <= 1'b0;
        end else begin
            sync <= sync_next;
        end
    end

endmodule

/* design/symbol_shaper.sv */
`timescale 1ns/1ps

// Pulse generator for one symbol at a time
// Each symbol is up to two pulses, every pulse a high part then a low part
module symbol_shaper (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,       // Alpha strobe
    input  logic                sym_start,  // With a tick, begins a symbol
    input  symbol_pkg::symbol_t sym_kind,   // Held by the sequencer for the symbol
    output logic                cod_o,      // Serial waveform, registered
    output logic                sym_done    // Tick that ends the last alpha
);

    logic                    busy;          // Symbol in progress
    logic                    phase;         // 0 first pulse, 1 second pulse
    logic                    high;          // In the high part of the pulse
    encoder_pkg::alpha_cnt_t cnt;           // Alphas done in the current part
    encoder_pkg::alpha_cnt_t hi_last;       // Last alpha index of high part
    encoder_pkg::alpha_cnt_t lo_last;       // Last alpha index of low part
    logic                    part_end;      // Current part finishes this tick
    logic                    last_part;     // Current part is the end of the symbol

    // Part lengths per kind and pulse
    // Kind is read live, it only matters from the first part end onwards
    always_comb begin
        hi_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::SHORT_ALPHA - 1);
        lo_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::LONG_ALPHA - 1);
        case (sym_kind)
            symbol_pkg::SYM_ZERO: begin
                // Default lengths, 4 high 12 low both pulses
            end
            symbol_pkg::SYM_ONE: begin
                hi_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::LONG_ALPHA - 1);
                lo_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::SHORT_ALPHA - 1);
            end
            symbol_pkg::SYM_FLOAT: begin
                if (phase) begin                  // Second pulse looks like a one
                    hi_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::LONG_ALPHA - 1);
                    lo_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::SHORT_ALPHA - 1);
                end
            end
            symbol_pkg::SYM_SYNC: begin
                // Single pulse, the gap fills the rest of 128 alpha
                lo_last = encoder_pkg::alpha_cnt_t'(encoder_pkg::SYNC_ALPHA
                                                    - encoder_pkg::SHORT_ALPHA - 1);
            end
            default: begin
            end
        endcase
    end

    assign part_end  = busy && tick && (cnt == (high ? hi_last : lo_last));
    assign last_part = !high && (phase || (sym_kind == symbol_pkg::SYM_SYNC));

    // Combinational so the next symbol can start on this very tick
    assign sym_done  = part_end && last_part;

    // Part sequencing
    // high0 -> low0 -> high1 -> low1, sync stops after low0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            phase <= 1'b0;
            high  <= 1'b0;
            cnt   <= '0;
            cod_o <= 1'b0;
        end else if (sym_start) begin
            busy  <= 1'b1;                  // Wins over the end of the previous symbol
            phase <= 1'b0;
            high  <= 1'b1;
            cnt   <= '0;
            cod_o <= 1'b1;                  // Every kind starts high
        end else if (part_end) begin
            cnt <= '0;
            if (high) begin
                high  <= 1'b0;              // High part over, drop the line
                cod_o <= 1'b0;
            end else if (last_part) begin
                busy <= 1'b0;               // Symbol over, line stays low
            end else begin
                phase <= 1'b1;              // On to the second pulse
                high  <= 1'b1;
                cod_o <= 1'b1;
            end
        end else if (busy && tick) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* design/code_register.sv */
`timescale 1ns/1ps

// Holds the word for the frame in flight
// Pins may change at any time, the frame only sees the captured copy
module code_register (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,     // One clock, at each frame start
    input  symbol_pkg::code_word_t code_in,  // Straight from the pins
    output symbol_pkg::code_word_t code      // Stable for the whole frame
);

    // Capture register
    // All zeros is every address at SYM_ZERO and data 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            code <= '0;
        end else if (load) begin
            code <= code_in;            // New word takes effect next clock
        end
    end

    // The sequencer starts symbol 0 in the same clock as load,
    // so the old word is still visible for that one clock.
    // Every symbol starts with a high level, and the shaper first
    // looks at the kind several ticks later, by then code is updated.

endmodule

/* design/osc_divider.sv */
`timescale 1ns/1ps

// Clocked stand-in for the RC oscillator
// One tick strobe per alpha, no derived clock
module osc_divider (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    encoder_pkg::osc_cnt_t cnt;      // Position inside the current alpha
    logic                  cnt_last; // Terminal count reached

    assign cnt_last = (cnt == encoder_pkg::osc_cnt_t'(encoder_pkg::OSC_DIV - 1));

    // Strobe on the terminal count, one clock wide
    assign tick = cnt_last;

    // Modulo OSC_DIV counter
    // Explicit wrap keeps non power of two ratios correct
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;                  // First tick OSC_DIV clocks after reset
        end else if (cnt_last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* design/symbol_pkg.sv */
package symbol_pkg;

    // Symbol kinds on the serial line
    // Zero must stay at encoding 0, the code register clears to it
    typedef enum logic [1:0] {
        SYM_ZERO  = 2'd0,   // Short high, long low, twice
        SYM_ONE   = 2'd1,   // Long high, short low, twice
        SYM_FLOAT = 2'd2,   // One zero pulse, then one one pulse
        SYM_SYNC  = 2'd3    // Short high, then the long gap
    } symbol_t;

    // Word sent in one frame, 20 bits
    // addr[0] goes out first, then data[0] after addr[7]
    typedef struct packed {
        symbol_t [encoder_pkg::NUM_ADDR-1:0] addr;  // A0..A7, each 0, 1 or F
        logic    [encoder_pkg::NUM_DATA-1:0] data;  // D0..D3
    } code_word_t;

endpackage

/* design/encoder_pkg.sv */
package encoder_pkg;

    // Oscillator divider
    localparam int OSC_DIV = 4;                    // Clocks per alpha
    localparam int OSC_W   = $clog2(OSC_DIV);      // Divider counter width

    // Pulse lengths, all in alpha
    localparam int SHORT_ALPHA = 4;                // Narrow pulse
    localparam int LONG_ALPHA  = 12;               // Wide pulse
    localparam int SYNC_ALPHA  = 128;              // Whole sync symbol, high plus gap
    localparam int ALPHA_W     = $clog2(SYNC_ALPHA);

    // Frame layout
    localparam int NUM_ADDR    = 8;                // Tri-state address symbols
    localparam int NUM_DATA    = 4;                // Binary data bits
    localparam int NUM_SYMBOLS = NUM_ADDR + NUM_DATA;  // 12 before the sync
    localparam int SYM_IDX_W   = $clog2(NUM_SYMBOLS + 1);  // Index 0..12
    localparam int ADDR_IDX_W  = $clog2(NUM_ADDR);
    localparam int DATA_IDX_W  = $clog2(NUM_DATA);

    // Counter and index types sized from the values above
    typedef logic [OSC_W-1:0]      osc_cnt_t;
    typedef logic [ALPHA_W-1:0]    alpha_cnt_t;
    typedef logic [SYM_IDX_W-1:0]  sym_idx_t;
    typedef logic [ADDR_IDX_W-1:0] addr_idx_t;
    typedef logic [DATA_IDX_W-1:0] data_idx_t;

endpackage
